// ==== tb.f ====
design/rv32_pkg.sv
design/core_sequencer.sv
design/program_counter.sv
design/instr_decoder.sv
design/alu.sv
design/register_file.sv
design/rv32_alu_core.sv
testbench/tb_rv32_alu_core.sv

// ==== Bender.yml ====
package:
  name: rv32_alu_core

sources:
  # Core RTL, package first
  - target: any(simulation, synthesis)
    files:
      - design/rv32_pkg.sv
      - design/core_sequencer.sv
      - design/program_counter.sv
      - design/instr_decoder.sv
      - design/alu.sv
      - design/register_file.sv
      - design/rv32_alu_core.sv

  # Testbench
  - target: test
    files:
      - testbench/tb_rv32_alu_core.sv

// ==== testbench/tb_rv32_alu_core.sv ====
`default_nettype none

module tb_rv32_alu_core;

    timeunit 1ns;
    timeprecision 1ps;

    localparam rv32_pkg::word_t RESET_PC = 32'h0000_1000;
    localparam int CLK_PERIOD   = 4;
    localparam int RESET_CYCLES = 8;
    localparam int NUM_INSTRS   = 2000;
    // Worst case is 9 fetch cycles plus decode, execute and writeback
    localparam int WATCHDOG_NS  = NUM_INSTRS * 12 * CLK_PERIOD + RESET_CYCLES * CLK_PERIOD;

    logic              clk;
    logic              reset;
    rv32_pkg::wb_req_t core_req;
    rv32_pkg::wb_rsp_t mem_rsp;
    rv32_pkg::retire_t retire;

    // Instruction memory filled on demand and keyed by fetch address
    rv32_pkg::word_t imem [rv32_pkg::word_t];

    // Reference state
    rv32_pkg::word_t model_regs [rv32_pkg::NUM_REGS];
    rv32_pkg::word_t model_pc;

    // Bus view sampled at the falling edge for the responder
    logic              stb_seen;
    logic              fetching;
    int                cycle;
    int                ack_cycle;
    int                retired;
    int                n_op;
    int                n_imm;
    int                n_nowrite;
    int                checks;
    int                word_errors;
    int                idx_errors;
    int                flag_errors;
    int                other_errors;

    rv32_alu_core #(
        .RESET_PC (RESET_PC)
    ) uut (
        .clk      (clk),
        .reset    (reset),
        .o_wb     (core_req),
        .i_wb     (mem_rsp),
        .o_retire (retire)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic check_word(input rv32_pkg::word_t got, input rv32_pkg::word_t exp,
                              input string what);
        checks++;
        if (got !== exp) begin
            word_errors++;
            $display("FAILED at %0t: %s got %08h, expected %08h", $time, what, got, exp);
        end
    endtask

    task automatic check_reg_idx(input rv32_pkg::reg_idx_t got, input rv32_pkg::reg_idx_t exp,
                                 input string what);
        checks++;
        if (got !== exp) begin
            idx_errors++;
            $display("FAILED at %0t: %s got x%0d, expected x%0d", $time, what, got, exp);
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        checks++;
        if (got !== exp) begin
            flag_errors++;
            $display("FAILED at %0t: %s got %b, expected %b", $time, what, got, exp);
        end
    endtask

    // Mostly legal OP and OP-IMM, some illegal encodings, some rd = x0
    function automatic rv32_pkg::word_t random_instr();
        int unsigned        kind;
        rv32_pkg::funct3_t  f3;
        rv32_pkg::funct7_t  f7;
        rv32_pkg::reg_idx_t rd;
        rv32_pkg::reg_idx_t rs1;
        rv32_pkg::reg_idx_t rs2;
        rv32_pkg::opcode_t  opc;
        logic [11:0]        imm;
        kind = $urandom_range(0, 99);
        f3   = 3'($urandom);
        rd   = 5'($urandom);
        rs1  = 5'($urandom);
        rs2  = 5'($urandom);
        imm  = 12'($urandom);
        if ($urandom_range(0, 7) == 0) begin
            rd = '0;
        end
        if (kind < 45) begin
            // ALT only where it selects SUB or SRA
            f7 = rv32_pkg::FUNCT7_BASE;
            if ((f3 == rv32_pkg::FUNCT3_ADD_SUB || f3 == rv32_pkg::FUNCT3_SRL_SRA)
                    && $urandom_range(0, 1) == 1) begin
                f7 = rv32_pkg::FUNCT7_ALT;
            end
            return {f7, rs2, rs1, f3, rd, rv32_pkg::OPCODE_OP};
        end else if (kind < 85) begin
            if (f3 == rv32_pkg::FUNCT3_SLL) begin
                imm[11:5] = rv32_pkg::FUNCT7_BASE;
            end else if (f3 == rv32_pkg::FUNCT3_SRL_SRA) begin
                imm[11:5] = imm[11] ? rv32_pkg::FUNCT7_ALT : rv32_pkg::FUNCT7_BASE;
            end
            return {imm, rs1, f3, rd, rv32_pkg::OPCODE_OP_IMM};
        end else if (kind < 95) begin
            // Illegal upper bits on OP or on an immediate shift
            f7 = 7'($urandom);
            if (f7 == rv32_pkg::FUNCT7_BASE || f7 == rv32_pkg::FUNCT7_ALT) begin
                f7 = 7'b1111111;
            end
            if (kind < 90) begin
                return {f7, rs2, rs1, f3, rd, rv32_pkg::OPCODE_OP};
            end
            return {f7, rs2, rs1, f3[2] ? 3'b101 : 3'b001, rd, rv32_pkg::OPCODE_OP_IMM};
        end else begin
            opc = 7'($urandom);
            if (opc == rv32_pkg::OPCODE_OP || opc == rv32_pkg::OPCODE_OP_IMM) begin
                opc = 7'b1111111;
            end
            return {imm, rs1, f3, rd, opc};
        end
    endfunction

    // ISA behavior on the reference registers
    function automatic void model_execute(input rv32_pkg::word_t instr, output logic wr,
                                          output rv32_pkg::word_t res);
        rv32_pkg::word_t a;
        rv32_pkg::word_t b;
        logic [2:0]      f3;
        logic            is_op;
        logic            is_imm;
        logic            f7_zero;
        logic            f7_alt;
        logic            shift;
        f3      = instr[14:12];
        is_op   = instr[6:0] == rv32_pkg::OPCODE_OP;
        is_imm  = instr[6:0] == rv32_pkg::OPCODE_OP_IMM;
        f7_zero = instr[31:25] == 7'b0000000;
        f7_alt  = instr[31:25] == 7'b0100000;
        shift   = f3 == 3'b001 || f3 == 3'b101;
        a = model_regs[instr[19:15]];
        b = is_imm ? {{20{instr[31]}}, instr[31:20]} : model_regs[instr[24:20]];
        // SUB on OP, SRA and SRAI take the alternate funct7
        wr = (is_op || is_imm) && (f7_zero || (is_imm && !shift)
             || (f7_alt && (f3 == 3'b101 || (f3 == 3'b000 && is_op))));
        case (f3)
            3'b000:  res = (is_op && f7_alt) ? a - b : a + b;
            3'b001:  res = a << b[4:0];
            3'b010:  res = {31'b0, $signed(a) < $signed(b)};
            3'b011:  res = {31'b0, a < b};
            3'b100:  res = a ^ b;
            3'b101:  res = f7_alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'b110:  res = a | b;
            default: res = a & b;
        endcase
        if (!wr) begin
            res = '0;
        end
    endfunction

    task automatic check_retirement();
        rv32_pkg::word_t    instr;
        rv32_pkg::word_t    exp_result;
        rv32_pkg::reg_idx_t rd;
        logic               exp_write;
        if (!imem.exists(model_pc)) begin
            other_errors++;
            $display("Error at %0t: retirement expected for %08h, which was never fetched",
                     $time, model_pc);
            return;
        end
        instr = imem[model_pc];
        rd    = instr[11:7];
        model_execute(instr, exp_write, exp_result);
        check_word(retire.pc, model_pc, "retire pc");
        check_word(retire.instr, instr, "retire instruction");
        check_reg_idx(retire.wb.rd, rd, "retire rd");
        check_flag(retire.wb.write, exp_write, "retire write flag");
        check_word(retire.wb.result, exp_result, "retire result");
        // x0 never changes in the model
        if (exp_write && rd != '0) begin
            model_regs[rd] = exp_result;
        end
        if (!exp_write) begin
            n_nowrite++;
        end else if (instr[6:0] == rv32_pkg::OPCODE_OP) begin
            n_op++;
        end else begin
            n_imm++;
        end
        model_pc += 32'd4;
        retired++;
    endtask

    // Memory side drives stimulus on the rising edge only
    task automatic serve_fetches();
        int unsigned     wait_left;
        logic            pending;
        rv32_pkg::word_t addr;
        pending = 1'b0;
        forever begin
            @(posedge clk);
            if (mem_rsp.ack) begin
                mem_rsp.ack <= 1'b0;
                mem_rsp.dat <= $urandom();
            end else if (stb_seen) begin
                if (!pending) begin
                    pending   = 1'b1;
                    addr      = core_req.adr;
                    wait_left = $urandom_range(0, 7);
                    imem[addr] = random_instr();
                end
                if (wait_left == 0) begin
                    mem_rsp.ack <= 1'b1;
                    mem_rsp.dat <= imem[addr];
                    pending = 1'b0;
                end else begin
                    wait_left--;
                end
            end
        end
    endtask

    // Protocol and retirement monitor at the falling edge
    always @(negedge clk) begin : monitor
        logic valid_exp;
        stb_seen = core_req.stb;
        if (reset) begin
            check_flag(core_req.cyc, 1'b0, "cyc in reset");
            check_flag(core_req.stb, 1'b0, "stb in reset");
            check_flag(retire.valid, 1'b0, "retire valid in reset");
        end else begin
            cycle++;
            // Request held through every wait state until ack
            check_flag(core_req.cyc, fetching, "cyc");
            check_flag(core_req.stb, fetching, "stb");
            if (fetching) begin
                check_word(core_req.adr, model_pc, "fetch address");
                if (mem_rsp.ack) begin
                    fetching  = 1'b0;
                    ack_cycle = cycle;
                end
            end
            valid_exp = !fetching && (cycle == ack_cycle + 3);
            check_flag(retire.valid, valid_exp, "retire valid");
            if (valid_exp) begin
                check_retirement();
                fetching = 1'b1;
            end
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout after %0d ns with %0d of %0d instructions retired",
                 WATCHDOG_NS, retired, NUM_INSTRS);
        $display("TESTS FAILED");
        $finish;
    end

    initial begin
        void'($urandom(32'hf012));
        reset    = 1'b1;
        mem_rsp  = '0;
        stb_seen = 1'b0;
        fetching = 1'b1;
        model_pc = RESET_PC;
        foreach (model_regs[i]) begin
            model_regs[i] = '0;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
        fork
            serve_fetches();
        join_none
        wait (retired == NUM_INSTRS);
        repeat (2) @(posedge clk);
        $display("Checks %0d retired %0d op %0d imm %0d nowrite %0d errors %0d/%0d/%0d/%0d",
                 checks, retired, n_op, n_imm, n_nowrite,
                 word_errors, idx_errors, flag_errors, other_errors);
        if (word_errors + idx_errors + flag_errors + other_errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== design/rv32_alu_core.sv ====
`default_nettype none

module rv32_alu_core #(
    parameter rv32_pkg::word_t RESET_PC = 32'h0000_0000
) (
    input  logic              clk,
    input  logic              reset,
    output rv32_pkg::wb_req_t o_wb,
    input  rv32_pkg::wb_rsp_t i_wb,
    output rv32_pkg::retire_t o_retire
);

    logic                 cyc;
    logic                 stb;
    logic                 load_instr;
    logic                 capture;
    logic                 commit;
    rv32_pkg::word_t      pc;
    rv32_pkg::word_t      instr;
    rv32_pkg::decoded_t   decoded;
    rv32_pkg::word_t      rs1_data;
    rv32_pkg::word_t      rs2_data;
    rv32_pkg::writeback_t writeback;

    core_sequencer u_sequencer (
        .clk          (clk),
        .reset        (reset),
        .i_ack        (i_wb.ack),
        .o_cyc        (cyc),
        .o_stb        (stb),
        .o_load_instr (load_instr),
        .o_capture    (capture),
        .o_commit     (commit)
    );

    program_counter #(
        .RESET_PC (RESET_PC)
    ) u_program_counter (
        .clk       (clk),
        .reset     (reset),
        .i_advance (commit),
        .o_pc      (pc)
    );

    instr_decoder u_instr_decoder (
        .clk       (clk),
        .reset     (reset),
        .i_load    (load_instr),
        .i_instr   (i_wb.dat),
        .o_instr   (instr),
        .o_decoded (decoded)
    );

    // Operand fetch from the decoder's register indices
    register_file u_register_file (
        .clk         (clk),
        .reset       (reset),
        .i_rs1       (decoded.rs1),
        .i_rs2       (decoded.rs2),
        .o_rs1_data  (rs1_data),
        .o_rs2_data  (rs2_data),
        .i_commit    (commit),
        .i_writeback (writeback)
    );

    alu u_alu (
        .clk         (clk),
        .reset       (reset),
        .i_capture   (capture),
        .i_decoded   (decoded),
        .i_rs1_data  (rs1_data),
        .i_rs2_data  (rs2_data),
        .o_writeback (writeback)
    );

    // Fetch address is the PC
    assign o_wb = '{cyc: cyc, stb: stb, adr: pc};

    // PC has not advanced yet during WRITEBACK
    assign o_retire = '{valid: commit, pc: pc, instr: instr, wb: writeback};

endmodule

`default_nettype wire

// ==== design/register_file.sv ====
`default_nettype none

module register_file (
    input  logic                 clk,
    input  logic                 reset,
    input  rv32_pkg::reg_idx_t   i_rs1,
    input  rv32_pkg::reg_idx_t   i_rs2,
    output rv32_pkg::word_t      o_rs1_data,
    output rv32_pkg::word_t      o_rs2_data,
    input  logic                 i_commit,
    input  rv32_pkg::writeback_t i_writeback
);

    rv32_pkg::word_t regs [rv32_pkg::NUM_REGS];
    rv32_pkg::word_t rs1_data_q;
    rv32_pkg::word_t rs2_data_q;

    // Write port never touches x0
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < rv32_pkg::NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (i_commit && i_writeback.write && (i_writeback.rd != '0)) begin
            regs[i_writeback.rd] <= i_writeback.result;
        end
    end

    // Synchronous read ports with one cycle latency
    // Index zero reads zero because x0 keeps its reset value
    always_ff @(posedge clk) begin
        rs1_data_q <= regs[i_rs1];
        rs2_data_q <= regs[i_rs2];
    end

    assign o_rs1_data = rs1_data_q;
    assign o_rs2_data = rs2_data_q;

    // x0 holds zero across every commit
    a_x0_zero : assert property (@(posedge clk) disable iff (reset)
        regs[0] == '0);

endmodule

`default_nettype wire

// ==== design/alu.sv ====
`default_nettype none

module alu (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 i_capture,
    input  rv32_pkg::decoded_t   i_decoded,
    input  rv32_pkg::word_t      i_rs1_data,
    input  rv32_pkg::word_t      i_rs2_data,
    output rv32_pkg::writeback_t o_writeback
);

    rv32_pkg::word_t      operand_b;
    rv32_pkg::word_t      result;
    logic [4:0]           shamt;
    rv32_pkg::writeback_t writeback_q;

    // Second operand select
    assign operand_b = i_decoded.use_imm ? i_decoded.imm : i_rs2_data;

    // Shift amount from low bits only, shamt field for immediates
    assign shamt = operand_b[4:0];

    always_comb begin
        case (i_decoded.alu_op)
            rv32_pkg::ALU_ADD:  result = i_rs1_data + operand_b;
            rv32_pkg::ALU_SUB:  result = i_rs1_data - operand_b;
            rv32_pkg::ALU_AND:  result = i_rs1_data & operand_b;
            rv32_pkg::ALU_OR:   result = i_rs1_data | operand_b;
            rv32_pkg::ALU_XOR:  result = i_rs1_data ^ operand_b;
            rv32_pkg::ALU_SLL:  result = i_rs1_data << shamt;
            rv32_pkg::ALU_SRL:  result = i_rs1_data >> shamt;
            rv32_pkg::ALU_SRA:  result = rv32_pkg::word_t'($signed(i_rs1_data) >>> shamt);
            rv32_pkg::ALU_SLT: begin
                result = rv32_pkg::word_t'($signed(i_rs1_data) < $signed(operand_b));
            end
            // Unsigned, even when the immediate was sign-extended
            rv32_pkg::ALU_SLTU: result = rv32_pkg::word_t'(i_rs1_data < operand_b);
            default:            result = '0;
        endcase
    end

    // Writeback record, held until the next capture
    always_ff @(posedge clk) begin
        if (reset) begin
            writeback_q <= '0;
        end else if (i_capture) begin
            writeback_q.rd     <= i_decoded.rd;
            writeback_q.result <= result;
            writeback_q.write  <= i_decoded.writes_rd;
        end
    end

    assign o_writeback = writeback_q;

endmodule

`default_nettype wire

// ==== design/instr_decoder.sv ====
`default_nettype none

module instr_decoder (
    input  logic               clk,
    input  logic               reset,
    input  logic               i_load,
    input  rv32_pkg::word_t    i_instr,
    output rv32_pkg::word_t    o_instr,
    output rv32_pkg::decoded_t o_decoded
);

    rv32_pkg::word_t   instr_q;
    rv32_pkg::opcode_t opcode;
    rv32_pkg::funct3_t funct3;
    rv32_pkg::funct7_t funct7;
    logic              is_op;
    logic              is_op_imm;
    logic              f7_base;
    logic              f7_alt;
    logic              plain_ok;
    rv32_pkg::alu_op_e alu_op;

    // Instruction register, loaded from the bus on ack
    always_ff @(posedge clk) begin
        if (reset) begin
            instr_q <= '0;
        end else if (i_load) begin
            instr_q <= i_instr;
        end
    end

    // Field extraction
    assign opcode = instr_q[6:0];
    assign funct3 = instr_q[14:12];
    assign funct7 = instr_q[31:25];

    assign is_op     = (opcode == rv32_pkg::OPCODE_OP);
    assign is_op_imm = (opcode == rv32_pkg::OPCODE_OP_IMM);

    // Same bits are imm[11:5] for OP-IMM shifts
    assign f7_base = (funct7 == rv32_pkg::FUNCT7_BASE);
    assign f7_alt  = (funct7 == rv32_pkg::FUNCT7_ALT);

    // Non-shift ops: OP needs base funct7, OP-IMM has immediate bits there
    assign plain_ok = is_op_imm || f7_base;

    always_comb begin
        alu_op = rv32_pkg::ALU_NONE;
        if (is_op || is_op_imm) begin
            case (funct3)
                rv32_pkg::FUNCT3_ADD_SUB: begin
                    if (plain_ok) begin
                        alu_op = rv32_pkg::ALU_ADD;
                    end else if (f7_alt) begin
                        // SUB exists only as a register form
                        alu_op = rv32_pkg::ALU_SUB;
                    end
                end
                rv32_pkg::FUNCT3_SLL: begin
                    if (f7_base) begin
                        alu_op = rv32_pkg::ALU_SLL;
                    end
                end
                rv32_pkg::FUNCT3_SRL_SRA: begin
                    if (f7_base) begin
                        alu_op = rv32_pkg::ALU_SRL;
                    end else if (f7_alt) begin
                        alu_op = rv32_pkg::ALU_SRA;
                    end
                end
                rv32_pkg::FUNCT3_SLT:  alu_op = plain_ok ? rv32_pkg::ALU_SLT : rv32_pkg::ALU_NONE;
                rv32_pkg::FUNCT3_SLTU: alu_op = plain_ok ? rv32_pkg::ALU_SLTU : rv32_pkg::ALU_NONE;
                rv32_pkg::FUNCT3_XOR:  alu_op = plain_ok ? rv32_pkg::ALU_XOR : rv32_pkg::ALU_NONE;
                rv32_pkg::FUNCT3_OR:   alu_op = plain_ok ? rv32_pkg::ALU_OR : rv32_pkg::ALU_NONE;
                rv32_pkg::FUNCT3_AND:  alu_op = plain_ok ? rv32_pkg::ALU_AND : rv32_pkg::ALU_NONE;
                default:               alu_op = rv32_pkg::ALU_NONE;
            endcase
        end
    end

    // Decoded record
    assign o_decoded.alu_op    = alu_op;
    assign o_decoded.rs1       = (is_op || is_op_imm) ? instr_q[19:15] : '0;
    assign o_decoded.rs2       = is_op ? instr_q[24:20] : '0;
    assign o_decoded.rd        = instr_q[11:7];
    assign o_decoded.imm       = {{(rv32_pkg::XLEN - 12){instr_q[31]}}, instr_q[31:20]};
    assign o_decoded.use_imm   = is_op_imm;
    assign o_decoded.writes_rd = (alu_op != rv32_pkg::ALU_NONE);

    assign o_instr = instr_q;

endmodule

`default_nettype wire

// ==== design/program_counter.sv ====
`default_nettype none

module program_counter #(
    parameter rv32_pkg::word_t RESET_PC = 32'h0000_0000
) (
    input  logic            clk,
    input  logic            reset,
    input  logic            i_advance,
    output rv32_pkg::word_t o_pc
);

    rv32_pkg::word_t pc_q;

    // Sequential flow only, wraps at the top of the address space
    always_ff @(posedge clk) begin
        if (reset) begin
            pc_q <= RESET_PC;
        end else if (i_advance) begin
            pc_q <= pc_q + rv32_pkg::word_t'(4);
        end
    end

    assign o_pc = pc_q;

    // Catches a misaligned RESET_PC as well
    a_pc_aligned : assert property (@(posedge clk) disable iff (reset)
        o_pc[1:0] == 2'b00);

endmodule

`default_nettype wire

// ==== design/core_sequencer.sv ====
`default_nettype none

module core_sequencer (
    input  logic clk,
    input  logic reset,
    input  logic i_ack,
    output logic o_cyc,
    output logic o_stb,
    output logic o_load_instr,
    output logic o_capture,
    output logic o_commit
);

    rv32_pkg::seq_state_e state_q;
    rv32_pkg::seq_state_e state_d;

    // Next state
    always_comb begin
        state_d = state_q;
        case (state_q)
            // Stay here for as many wait states as the memory needs
            rv32_pkg::SEQ_FETCH: begin
                if (i_ack) begin
                    state_d = rv32_pkg::SEQ_DECODE;
                end
            end
            rv32_pkg::SEQ_DECODE:    state_d = rv32_pkg::SEQ_EXECUTE;
            rv32_pkg::SEQ_EXECUTE:   state_d = rv32_pkg::SEQ_WRITEBACK;
            rv32_pkg::SEQ_WRITEBACK: state_d = rv32_pkg::SEQ_FETCH;
            default:                 state_d = rv32_pkg::SEQ_FETCH;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q <= rv32_pkg::SEQ_FETCH;
        end else begin
            state_q <= state_d;
        end
    end

    // Bus request for the whole FETCH state and quiet while reset is held
    assign o_cyc = (state_q == rv32_pkg::SEQ_FETCH) && !reset;
    assign o_stb = (state_q == rv32_pkg::SEQ_FETCH) && !reset;

    // Single-cycle strobes to the datapath
    assign o_load_instr = (state_q == rv32_pkg::SEQ_FETCH) && i_ack;
    assign o_capture    = (state_q == rv32_pkg::SEQ_EXECUTE);
    assign o_commit     = (state_q == rv32_pkg::SEQ_WRITEBACK);

    // Memory acks only a strobe inside an open bus cycle
    a_ack_in_cycle : assert property (@(posedge clk) disable iff (reset)
        i_ack |-> (o_cyc && o_stb));

    // At most one retirement per instruction pass
    a_commit_single : assert property (@(posedge clk) disable iff (reset)
        o_commit |=> !o_commit);

endmodule

`default_nettype wire

// ==== design/rv32_pkg.sv ====
`default_nettype none

package rv32_pkg;

    // Data path width and architectural register count
    localparam int XLEN     = 32;
    localparam int NUM_REGS = 32;

    // Plain vector types
    typedef logic [XLEN-1:0]             word_t;
    typedef logic [$clog2(NUM_REGS)-1:0] reg_idx_t;
    typedef logic [6:0]                  opcode_t;
    typedef logic [2:0]                  funct3_t;
    typedef logic [6:0]                  funct7_t;

    // Only the two integer compute opcodes are executed
    localparam opcode_t OPCODE_OP     = 7'b0110011;
    localparam opcode_t OPCODE_OP_IMM = 7'b0010011;

    // funct7, also imm[11:5] for immediate shifts
    localparam funct7_t FUNCT7_BASE = 7'b0000000;
    localparam funct7_t FUNCT7_ALT  = 7'b0100000;

    // funct3 encodings shared by OP and OP-IMM
    localparam funct3_t FUNCT3_ADD_SUB = 3'b000;
    localparam funct3_t FUNCT3_SLL     = 3'b001;
    localparam funct3_t FUNCT3_SLT     = 3'b010;
    localparam funct3_t FUNCT3_SLTU    = 3'b011;
    localparam funct3_t FUNCT3_XOR     = 3'b100;
    localparam funct3_t FUNCT3_SRL_SRA = 3'b101;
    localparam funct3_t FUNCT3_OR      = 3'b110;
    localparam funct3_t FUNCT3_AND     = 3'b111;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_SLT,
        ALU_SLTU,
        ALU_NONE
    } alu_op_e;

    // One pass through these per instruction
    typedef enum logic [1:0] {
        SEQ_FETCH,
        SEQ_DECODE,
        SEQ_EXECUTE,
        SEQ_WRITEBACK
    } seq_state_e;

    typedef struct packed {
        alu_op_e  alu_op;
        reg_idx_t rs1;
        reg_idx_t rs2;
        reg_idx_t rd;
        word_t    imm;        // sign-extended I-type immediate
        logic     use_imm;
        logic     writes_rd;
    } decoded_t;

    // Wishbone classic, read only
    typedef struct packed {
        logic  cyc;
        logic  stb;
        word_t adr;
    } wb_req_t;

    typedef struct packed {
        logic  ack;
        word_t dat;
    } wb_rsp_t;

    typedef struct packed {
        reg_idx_t rd;
        word_t    result;
        logic     write;
    } writeback_t;

    typedef struct packed {
        logic       valid;
        word_t      pc;
        word_t      instr;
        writeback_t wb;
    } retire_t;

endpackage

`default_nettype wire
